// File: verilog/revo_pkg.sv
package revo_pkg;

	localparam int axil_addr_width = 5;
	localparam int axil_data_width = 32;
	localparam int cal_word_width = 8;
	localparam int revo_count_width = 16;

	typedef logic [axil_addr_width-1:0] axil_addr_t;
	typedef logic [axil_data_width-1:0] axil_data_t;
	typedef logic [cal_word_width-1:0] cal_word_t;
	// Wraps around on overflow
	typedef logic [revo_count_width-1:0] revo_count_t;

	// Quiet window and total depth of the revo sample history
	localparam int quiet_samples = 8;
	localparam int history_width = 16;

	// Register map
	localparam axil_addr_t addr_control = 5'h00;
	localparam axil_addr_t addr_cal_word0 = 5'h04;
	localparam axil_addr_t addr_cal_word1 = 5'h08;
	localparam axil_addr_t addr_revo_count = 5'h0C;
	localparam axil_addr_t addr_status = 5'h10;

	// Control register bits
	localparam int ctrl_encode_enable_bit = 0;
	localparam int ctrl_serial_enable_bit = 1;

	// Status register bits
	localparam int status_pending_bit = 0;

	localparam logic [1:0] resp_okay = 2'b00;

	typedef enum logic [1:0] {
		run,
		wait_boundary,
		suppress
	} encoder_state_t;

endpackage

// File: verilog/revo_detector.sv
`timescale 1ns/1ps

module revo_detector (
	input logic clock509,
	input logic reset,
	input logic revo,
	output logic revo_accept
);

	// Newest sample enters at bit 0
	logic [revo_pkg::history_width-1:0] history;

	// Quiet window, the older samples
	logic [revo_pkg::quiet_samples-1:0] older_half;

	// Capture window, the newer samples
	logic [revo_pkg::history_width-revo_pkg::quiet_samples-1:0] newer_half;

	logic older_quiet;
	logic newer_first;

	assign older_quiet = (older_half == '0);

	// Only the newest sample set means the capture window just became nonzero
	assign newer_first = newer_half[0] &&
		(newer_half[revo_pkg::history_width-revo_pkg::quiet_samples-1:1] == '0);

	always_ff @(posedge clock509) begin
		if (reset) begin
			history <= '0;
			older_half <= '0;
			newer_half <= '0;
			revo_accept <= 1'b0;
		end else begin
			history <= {history[revo_pkg::history_width-2:0], revo};
			older_half <= history[revo_pkg::history_width-1:
				revo_pkg::history_width-revo_pkg::quiet_samples];
			newer_half <= history[revo_pkg::history_width-revo_pkg::quiet_samples-1:0];
			// Second compare stage, three edges after the sample
			revo_accept <= older_quiet && newer_first;
		end
	end

endmodule

// File: verilog/revo_clock_encoder.sv
`timescale 1ns/1ps

module revo_clock_encoder (
	input logic clock509,
	input logic reset,
	input logic revo_accept,
	input logic encode_enable,
	output logic ref_clock,
	output logic encoded_clock,
	output logic revo_pending
);

	// Free-running divide by four, high for phases 2 and 3
	logic [1:0] phase;
	logic last_phase;

	revo_pkg::encoder_state_t state;

	assign last_phase = (phase == 2'd3);

	always_ff @(posedge clock509) begin
		if (reset) begin
			phase <= 2'd0;
			state <= revo_pkg::run;
		end else begin
			phase <= phase + 2'd1;
			case (state)
				revo_pkg::run: begin
					if (revo_accept && encode_enable) begin
						// Already at the boundary, so the next period is dropped
						if (last_phase) begin
							state <= revo_pkg::suppress;
						end else begin
							state <= revo_pkg::wait_boundary;
						end
					end
				end
				revo_pkg::wait_boundary: begin
					if (last_phase) begin
						state <= revo_pkg::suppress;
					end
				end
				revo_pkg::suppress: begin
					// One whole period held low
					if (last_phase) begin
						state <= revo_pkg::run;
					end
				end
				default: begin
					state <= revo_pkg::run;
				end
			endcase
		end
	end

	assign ref_clock = phase[1];

	// Receiver recovers the marker as ref_clock xor encoded_clock
	assign encoded_clock = phase[1] && (state != revo_pkg::suppress);

	// Further accepts merge while a revolution is pending
	assign revo_pending = (state != revo_pkg::run);

endmodule

// File: verilog/calibration_serializer.sv
`timescale 1ns/1ps

module calibration_serializer (
	input logic clock509,
	input logic reset,
	input logic serial_enable,
	input logic lemo,
	input revo_pkg::cal_word_t cal_word0,
	input revo_pkg::cal_word_t cal_word1,
	output logic serial_data,
	output logic word_start
);

	// Word framing, load happens when the count is zero
	logic [2:0] bit_count;
	revo_pkg::cal_word_t shift_word;
	revo_pkg::cal_word_t next_word;

	// lemo high picks word 0
	assign next_word = lemo ? cal_word0 : cal_word1;

	always_ff @(posedge clock509) begin
		if (reset) begin
			bit_count <= 3'd0;
			shift_word <= '0;
			word_start <= 1'b0;
		end else if (!serial_enable) begin
			bit_count <= 3'd0;
			shift_word <= '0;
			word_start <= 1'b0;
		end else begin
			bit_count <= bit_count + 3'd1;
			if (bit_count == 3'd0) begin
				shift_word <= next_word;
				word_start <= 1'b1;
			end else begin
				shift_word <= {shift_word[revo_pkg::cal_word_width-2:0], 1'b0};
				word_start <= 1'b0;
			end
		end
	end

	// MSB first, bit 7 goes out with word_start
	assign serial_data = shift_word[revo_pkg::cal_word_width-1];

endmodule

// File: verilog/revo_regs.sv
`timescale 1ns/1ps

module revo_regs (
	input logic clock509,
	input logic reset,

	input revo_pkg::axil_addr_t s_awaddr,
	input logic s_awvalid,
	output logic s_awready,
	input revo_pkg::axil_data_t s_wdata,
	input logic [3:0] s_wstrb,
	input logic s_wvalid,
	output logic s_wready,
	output logic [1:0] s_bresp,
	output logic s_bvalid,
	input logic s_bready,
	input revo_pkg::axil_addr_t s_araddr,
	input logic s_arvalid,
	output logic s_arready,
	output revo_pkg::axil_data_t s_rdata,
	output logic [1:0] s_rresp,
	output logic s_rvalid,
	input logic s_rready,

	input logic revo_accept,
	input logic revo_pending,

	output logic encode_enable,
	output logic serial_enable,
	output revo_pkg::cal_word_t cal_word0,
	output revo_pkg::cal_word_t cal_word1
);

	logic write_accept;
	logic read_accept;
	logic count_clear;

	revo_pkg::revo_count_t revo_count;
	revo_pkg::axil_data_t read_word;

	// Held responses block new acceptance on their channel
	assign write_accept = s_awvalid && s_wvalid && !s_bvalid;
	assign read_accept = s_arvalid && !s_rvalid;

	assign s_awready = write_accept;
	assign s_wready = write_accept;
	assign s_arready = read_accept;

	assign s_bresp = revo_pkg::resp_okay;
	assign s_rresp = revo_pkg::resp_okay;

	assign count_clear = write_accept && (s_awaddr == revo_pkg::addr_revo_count);

	always_ff @(posedge clock509) begin
		if (reset) begin
			encode_enable <= 1'b0;
			serial_enable <= 1'b0;
			cal_word0 <= '0;
			cal_word1 <= '0;
			s_bvalid <= 1'b0;
		end else begin
			if (write_accept) begin
				s_bvalid <= 1'b1;
			end else if (s_bready) begin
				s_bvalid <= 1'b0;
			end
			// All fields live in byte lane 0
			if (write_accept && s_wstrb[0]) begin
				case (s_awaddr)
					revo_pkg::addr_control: begin
						encode_enable <= s_wdata[revo_pkg::ctrl_encode_enable_bit];
						serial_enable <= s_wdata[revo_pkg::ctrl_serial_enable_bit];
					end
					revo_pkg::addr_cal_word0: cal_word0 <= s_wdata[revo_pkg::cal_word_width-1:0];
					revo_pkg::addr_cal_word1: cal_word1 <= s_wdata[revo_pkg::cal_word_width-1:0];
					default: begin
					end
				endcase
			end
		end
	end

	// Clear and increment together leave one
	always_ff @(posedge clock509) begin
		if (reset) begin
			revo_count <= '0;
		end else if (count_clear) begin
			revo_count <= revo_accept ? revo_pkg::revo_count_t'(1) : '0;
		end else if (revo_accept) begin
			revo_count <= revo_count + revo_pkg::revo_count_t'(1);
		end
	end

	always_comb begin
		read_word = '0;
		case (s_araddr)
			revo_pkg::addr_control: begin
				read_word[revo_pkg::ctrl_encode_enable_bit] = encode_enable;
				read_word[revo_pkg::ctrl_serial_enable_bit] = serial_enable;
			end
			revo_pkg::addr_cal_word0: read_word[revo_pkg::cal_word_width-1:0] = cal_word0;
			revo_pkg::addr_cal_word1: read_word[revo_pkg::cal_word_width-1:0] = cal_word1;
			revo_pkg::addr_revo_count: read_word[revo_pkg::revo_count_width-1:0] = revo_count;
			revo_pkg::addr_status: read_word[revo_pkg::status_pending_bit] = revo_pending;
			default: read_word = '0;
		endcase
	end

	always_ff @(posedge clock509) begin
		if (reset) begin
			s_rvalid <= 1'b0;
			s_rdata <= '0;
		end else begin
			if (read_accept) begin
				s_rvalid <= 1'b1;
				s_rdata <= read_word;
			end else if (s_rready) begin
				s_rvalid <= 1'b0;
			end
		end
	end

endmodule

// File: verilog/revo_timing_top.sv
`timescale 1ns/1ps

module revo_timing_top (
	input logic clock509,
	input logic reset,
	input logic revo,
	input logic lemo,

	input revo_pkg::axil_addr_t s_awaddr,
	input logic s_awvalid,
	output logic s_awready,
	input revo_pkg::axil_data_t s_wdata,
	input logic [3:0] s_wstrb,
	input logic s_wvalid,
	output logic s_wready,
	output logic [1:0] s_bresp,
	output logic s_bvalid,
	input logic s_bready,
	input revo_pkg::axil_addr_t s_araddr,
	input logic s_arvalid,
	output logic s_arready,
	output revo_pkg::axil_data_t s_rdata,
	output logic [1:0] s_rresp,
	output logic s_rvalid,
	input logic s_rready,

	output logic ref_clock,
	output logic encoded_clock,
	output logic serial_data,
	output logic word_start
);

	logic revo_accept;
	logic revo_pending;
	logic encode_enable;
	logic serial_enable;
	revo_pkg::cal_word_t cal_word0;
	revo_pkg::cal_word_t cal_word1;

	// Register block steering the datapath
	revo_regs u_regs (
		.clock509(clock509),
		.reset(reset),
		.s_awaddr(s_awaddr),
		.s_awvalid(s_awvalid),
		.s_awready(s_awready),
		.s_wdata(s_wdata),
		.s_wstrb(s_wstrb),
		.s_wvalid(s_wvalid),
		.s_wready(s_wready),
		.s_bresp(s_bresp),
		.s_bvalid(s_bvalid),
		.s_bready(s_bready),
		.s_araddr(s_araddr),
		.s_arvalid(s_arvalid),
		.s_arready(s_arready),
		.s_rdata(s_rdata),
		.s_rresp(s_rresp),
		.s_rvalid(s_rvalid),
		.s_rready(s_rready),
		.revo_accept(revo_accept),
		.revo_pending(revo_pending),
		.encode_enable(encode_enable),
		.serial_enable(serial_enable),
		.cal_word0(cal_word0),
		.cal_word1(cal_word1)
	);

	revo_detector u_detector (
		.clock509(clock509),
		.reset(reset),
		.revo(revo),
		.revo_accept(revo_accept)
	);

	revo_clock_encoder u_encoder (
		.clock509(clock509),
		.reset(reset),
		.revo_accept(revo_accept),
		.encode_enable(encode_enable),
		.ref_clock(ref_clock),
		.encoded_clock(encoded_clock),
		.revo_pending(revo_pending)
	);

	calibration_serializer u_serializer (
		.clock509(clock509),
		.reset(reset),
		.serial_enable(serial_enable),
		.lemo(lemo),
		.cal_word0(cal_word0),
		.cal_word1(cal_word1),
		.serial_data(serial_data),
		.word_start(word_start)
	);

endmodule

// File: dv/tb_axil_tasks.svh
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

task automatic check_value(
	input logic [255:0] test_name,
	input logic [31:0] expected,
	input logic [31:0] actual
);
	if (expected !== actual) begin
		error_count = error_count + 1;
		$display("Error: test %0s expected 0x%08h actual 0x%08h", test_name, expected, actual);
	end
endtask

task automatic report_timeout(input string what, input int limit);
	timeout_count = timeout_count + 1;
	$display("Timeout in test %0s: %0s did not happen within %0d cycles",
		current_test, what, limit);
endtask

task automatic write_register(
	input revo_pkg::axil_addr_t addr,
	input revo_pkg::axil_data_t data,
	input logic [3:0] strb
);
	int cycles;
	@(posedge clock509);
	s_awaddr <= addr;
	s_wdata <= data;
	s_wstrb <= strb;
	s_awvalid <= 1'b1;
	s_wvalid <= 1'b1;
	s_bready <= 1'b1;
	cycles = 0;
	@(negedge clock509);
	while (!(s_awready && s_wready) && cycles < handshake_limit) begin
		@(negedge clock509);
		cycles++;
	end
	if (!(s_awready && s_wready)) begin
		report_timeout("write address and data acceptance", handshake_limit);
	end
	@(posedge clock509);
	s_awvalid <= 1'b0;
	s_wvalid <= 1'b0;
	cycles = 0;
	@(negedge clock509);
	while (!s_bvalid && cycles < handshake_limit) begin
		@(negedge clock509);
		cycles++;
	end
	if (!s_bvalid) begin
		report_timeout("write response", handshake_limit);
	end else begin
		// OKAY response
		check_value(current_test, 32'd0, {30'd0, s_bresp});
	end
	@(posedge clock509);
	s_bready <= 1'b0;
endtask

task automatic read_register(input revo_pkg::axil_addr_t addr, output revo_pkg::axil_data_t data);
	int cycles;
	@(posedge clock509);
	s_araddr <= addr;
	s_arvalid <= 1'b1;
	s_rready <= 1'b1;
	cycles = 0;
	@(negedge clock509);
	while (!s_arready && cycles < handshake_limit) begin
		@(negedge clock509);
		cycles++;
	end
	if (!s_arready) begin
		report_timeout("read address acceptance", handshake_limit);
	end
	@(posedge clock509);
	s_arvalid <= 1'b0;
	cycles = 0;
	@(negedge clock509);
	while (!s_rvalid && cycles < handshake_limit) begin
		@(negedge clock509);
		cycles++;
	end
	if (!s_rvalid) begin
		report_timeout("read data", handshake_limit);
	end else begin
		// OKAY response
		check_value(current_test, 32'd0, {30'd0, s_rresp});
	end
	data = s_rdata;
	@(posedge clock509);
	s_rready <= 1'b0;
endtask

`endif

// File: dv/tb_revo_timing.sv
`timescale 1ns/1ps

module tb_revo_timing;

	localparam int handshake_limit = 32;
	localparam int settle_cycles = 4;

	logic clock509 = 1'b0;
	logic reset;
	logic revo;
	logic lemo;
	revo_pkg::axil_addr_t s_awaddr;
	logic s_awvalid;
	logic s_awready;
	revo_pkg::axil_data_t s_wdata;
	logic [3:0] s_wstrb;
	logic s_wvalid;
	logic s_wready;
	logic [1:0] s_bresp;
	logic s_bvalid;
	logic s_bready;
	revo_pkg::axil_addr_t s_araddr;
	logic s_arvalid;
	logic s_arready;
	revo_pkg::axil_data_t s_rdata;
	logic [1:0] s_rresp;
	logic s_rvalid;
	logic s_rready;
	logic ref_clock;
	logic encoded_clock;
	logic serial_data;
	logic word_start;

	int seed = 28948;
	int error_count = 0;
	int timeout_count = 0;
	logic [255:0] current_test;

	// Serial capture, each byte tagged with the epoch current at its word_start
	int capture_epoch = 0;
	int bits_seen = 0;
	int byte_tag = 0;
	logic [7:0] byte_shift = 8'd0;
	logic [7:0] byte_q[$];
	int tag_q[$];
	int activity_total = 0;
	int activity_base = 0;

	int suppressed_total = 0;
	int suppressed_base = 0;
	logic ref_prev = 1'b0;
	int ref_rises = 0;
	int ref_cycles = 0;

	always #4 clock509 = ~clock509;

	revo_timing_top u_dut (
		.clock509(clock509),
		.reset(reset),
		.revo(revo),
		.lemo(lemo),
		.s_awaddr(s_awaddr),
		.s_awvalid(s_awvalid),
		.s_awready(s_awready),
		.s_wdata(s_wdata),
		.s_wstrb(s_wstrb),
		.s_wvalid(s_wvalid),
		.s_wready(s_wready),
		.s_bresp(s_bresp),
		.s_bvalid(s_bvalid),
		.s_bready(s_bready),
		.s_araddr(s_araddr),
		.s_arvalid(s_arvalid),
		.s_arready(s_arready),
		.s_rdata(s_rdata),
		.s_rresp(s_rresp),
		.s_rvalid(s_rvalid),
		.s_rready(s_rready),
		.ref_clock(ref_clock),
		.encoded_clock(encoded_clock),
		.serial_data(serial_data),
		.word_start(word_start)
	);

	`include "tb_axil_tasks.svh"

	// A ref_clock rise without encoded_clock is one dropped period
	always @(negedge clock509) begin
		if (ref_clock && !ref_prev) begin
			if (!encoded_clock) begin
				suppressed_total = suppressed_total + 1;
			end
			// Divide by four, one rise every four cycles
			if (ref_rises > 0) begin
				check_value(current_test, 32'd4, ref_cycles);
			end
			ref_rises = ref_rises + 1;
			ref_cycles = 0;
		end
		ref_cycles = ref_cycles + 1;
		// Encoded clock stays low while the reference is low
		if (!ref_clock) begin
			check_value(current_test, 32'd0, {31'd0, encoded_clock});
		end
		ref_prev = ref_clock;
	end

	always @(negedge clock509) begin
		if (word_start) begin
			byte_shift = {7'd0, serial_data};
			bits_seen = 1;
			byte_tag = capture_epoch;
		end else if (bits_seen != 0) begin
			byte_shift = {byte_shift[6:0], serial_data};
			bits_seen = bits_seen + 1;
		end
		if (bits_seen == 8) begin
			byte_q.push_back(byte_shift);
			tag_q.push_back(byte_tag);
			bits_seen = 0;
		end
		if (word_start || serial_data) begin
			activity_total = activity_total + 1;
		end
	end

	function automatic int words_in_epoch(input int epoch);
		int total;
		int i;
		total = 0;
		for (i = 0; i < tag_q.size(); i++) begin
			if (tag_q[i] == epoch) begin
				total++;
			end
		end
		return total;
	endfunction

	task automatic drive_revo(input int low_cycles, input int high_cycles);
		int i;
		for (i = 0; i < low_cycles; i++) begin
			@(posedge clock509);
			revo <= 1'b0;
		end
		for (i = 0; i < high_cycles; i++) begin
			@(posedge clock509);
			revo <= 1'b1;
		end
		@(posedge clock509);
		revo <= 1'b0;
		// Detector latency is three edges, the counter follows one edge later
		repeat (settle_cycles) @(posedge clock509);
	endtask

	task automatic expect_words(input int count, input logic [7:0] expected_byte);
		int cycles;
		int limit;
		int checked;
		int i;
		limit = count * 8 + 24;
		@(posedge clock509);
		capture_epoch = capture_epoch + 1;
		activity_base = activity_total;
		if (count == 0) begin
			// Idle line, watch a window for any activity
			repeat (limit) @(posedge clock509);
			check_value(current_test, 32'd0, activity_total - activity_base);
		end else begin
			cycles = 0;
			while (words_in_epoch(capture_epoch) < count && cycles < limit) begin
				@(posedge clock509);
				cycles++;
			end
			if (words_in_epoch(capture_epoch) < count) begin
				report_timeout("capture of serial words", limit);
			end
			checked = 0;
			for (i = 0; i < byte_q.size(); i++) begin
				if (tag_q[i] == capture_epoch && checked < count) begin
					check_value(current_test, {24'd0, expected_byte}, {24'd0, byte_q[i]});
					checked++;
				end
			end
		end
	endtask

	task automatic expect_suppressed(input int expected_count);
		int cycles;
		cycles = 0;
		@(negedge clock509);
		while (u_dut.revo_pending && cycles < handshake_limit) begin
			@(negedge clock509);
			cycles++;
		end
		if (u_dut.revo_pending) begin
			report_timeout("end of clock suppression", handshake_limit);
		end
		@(posedge clock509);
		check_value(current_test, expected_count, suppressed_total - suppressed_base);
		suppressed_base = suppressed_total;
	endtask

	task automatic run_step(
		input logic [255:0] cmd,
		input logic [31:0] a,
		input logic [31:0] b,
		input logic [31:0] c
	);
		revo_pkg::axil_data_t read_data;
		if (cmd == "write") begin
			write_register(a[4:0], b, c[3:0]);
		end else if (cmd == "read") begin
			read_register(a[4:0], read_data);
			check_value(current_test, b, read_data);
		end else if (cmd == "revo") begin
			drive_revo(a, b);
		end else if (cmd == "lemo") begin
			@(posedge clock509);
			lemo <= a[0];
		end else if (cmd == "expect_words") begin
			expect_words(a, b[7:0]);
		end else if (cmd == "expect_suppressed") begin
			expect_suppressed(a);
		end else begin
			error_count = error_count + 1;
			$display("Unknown command %0s in golden file for test %0s", cmd, current_test);
		end
	endtask

	initial begin
		int fd;
		int n;
		int fields;
		int gap;
		int steps;
		logic [8*128-1:0] line;
		logic [255:0] name;
		logic [255:0] cmd;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		steps = 0;
		current_test = "reset";
		reset <= 1'b1;
		revo <= 1'b0;
		lemo <= 1'b0;
		s_awaddr <= '0;
		s_awvalid <= 1'b0;
		s_wdata <= '0;
		s_wstrb <= 4'h0;
		s_wvalid <= 1'b0;
		s_bready <= 1'b0;
		s_araddr <= '0;
		s_arvalid <= 1'b0;
		s_rready <= 1'b0;
		repeat (5) @(posedge clock509);
		reset <= 1'b0;

		fd = $fopen("dv/revo_golden.txt", "r");
		if (fd == 0) begin
			error_count = error_count + 1;
			$display("Could not open the golden file dv/revo_golden.txt");
		end else begin
			while (!$feof(fd)) begin
				line = '0;
				n = $fgets(line, fd);
				if (n > 0) begin
					fields = $sscanf(line, "%s %s %h %h %h", name, cmd, a, b, c);
					if (fields >= 1 && name == "#") begin
						continue;
					end else if (fields == 5) begin
						current_test = name;
						// Random idle gap, short enough to keep the quiet-window test valid
						gap = ($random(seed) & 32'h7fffffff) % 3;
						repeat (gap) @(posedge clock509);
						run_step(cmd, a, b, c);
						steps++;
					end else if (fields > 0) begin
						error_count = error_count + 1;
						$display("Golden file line could not be parsed: %0s", line);
					end
				end
			end
			$fclose(fd);
		end
		if (steps == 0) begin
			error_count = error_count + 1;
			$display("No golden steps were run");
		end

		repeat (4) @(posedge clock509);
		$display("Errors: %0d, timeouts: %0d", error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// File: revo_timing.f
+incdir+dv
verilog/revo_pkg.sv
verilog/revo_detector.sv
verilog/revo_clock_encoder.sv
verilog/calibration_serializer.sv
verilog/revo_regs.sv
verilog/revo_timing_top.sv
dv/tb_revo_timing.sv

// File: run_sim.sh
#!/bin/sh
# Builds the revo timing testbench with Verilator, runs it and judges the log

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing -f revo_timing.f --top-module tb_revo_timing -o tb_revo_timing
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/tb_revo_timing > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^All checks passed$" "$log_file"; then
	echo "Simulation PASS"
	exit 0
else
	echo "Simulation FAIL"
	exit 1
fi

// File: dv/revo_golden.txt
# name command a b c, all values hex
# write a=addr b=data c=wstrb, read a=addr b=expected, revo a=low b=high, lemo a=level, expect_words a=count b=byte, expect_suppressed a=count
reset_values read 00 0 0
reset_values read 0c 0 0
reset_values read 10 0 0
reg_access write 04 a5 f
reg_access read 04 a5 0
reg_access write 08 3c f
reg_access read 08 3c 0
reg_strobe write 04 ffffff11 e
reg_strobe read 04 a5 0
reg_strobe write 08 12345677 1
reg_strobe read 08 77 0
unknown_addr write 14 ffffffff f
unknown_addr read 14 0 0
unknown_addr read 1c 0 0
control_rw write 00 3 f
control_rw read 00 3 0
control_rw write 00 0 f
control_rw read 00 0 0
quiet_filter revo 14 2 0
quiet_filter revo 14 5 0
quiet_filter revo 0 3 0
quiet_filter revo 18 1 0
quiet_filter read 0c 3 0
encode_on write 00 1 f
encode_on expect_suppressed 0 0 0
encode_on revo 14 2 0
encode_on revo 14 4 0
encode_on expect_suppressed 2 0 0
encode_off write 00 0 f
encode_off revo 14 2 0
encode_off expect_suppressed 0 0 0
count_clear write 0c 0 f
count_clear read 0c 0 0
count_clear revo 14 2 0
count_clear revo 14 3 0
count_clear read 0c 2 0
serial_on write 04 a5 f
serial_on write 08 3c f
serial_on write 00 2 f
serial_lemo lemo 1 0 0
serial_lemo expect_words 3 a5 0
serial_lemo lemo 0 0 0
serial_lemo expect_words 3 3c 0
serial_off write 00 0 f
serial_off expect_words 0 0 0
status read 10 0 0
